// File: src/axis_cfg.svh
`ifndef AXIS_CFG_SVH
`define AXIS_CFG_SVH

// width of one stream beat in bits
`define AXIS_DATA_WIDTH 8

// log2 of the elastic fifo depth
// 4 gives 16 entries
`define AXIS_FIFO_ADDR_WIDTH 4

// shortest good frame in beats
`define AXIS_MIN_FRAME 4

// longest good frame in beats
`define AXIS_MAX_FRAME 12

// beat counter width, must hold AXIS_MAX_FRAME+1
`define AXIS_LEN_WIDTH 5

// frame statistics counter width
`define AXIS_CNT_WIDTH 16

`endif

// File: src/axis_pkg.sv
`include "axis_cfg.svh"

package axis_pkg;

    // one beat of stream payload
    typedef logic [`AXIS_DATA_WIDTH-1:0] data_t;

    // beats seen so far in the current frame
    // saturates one past the upper length limit
    typedef logic [`AXIS_LEN_WIDTH-1:0] len_t;

    // delivered frame and bad frame counters
    // wrap on overflow
    typedef logic [`AXIS_CNT_WIDTH-1:0] cnt_t;

endpackage

// File: src/axis_frame_check.sv
`include "axis_cfg.svh"

module axis_frame_check (
    input  logic            clk,
    input  logic            nrst,

    // upstream beat stream
    input  axis_pkg::data_t in_tdata,
    input  logic            in_tvalid,
    output logic            in_tready,
    input  logic            in_tlast,
    input  logic            in_tuser,

    // checked beat stream, user set on bad length
    output axis_pkg::data_t out_tdata,
    output logic            out_tvalid,
    input  logic            out_tready,
    output logic            out_tlast,
    output logic            out_tuser
);

    // length limits in counter width
    localparam axis_pkg::len_t MIN_LEN = axis_pkg::len_t'(`AXIS_MIN_FRAME);
    localparam axis_pkg::len_t MAX_LEN = axis_pkg::len_t'(`AXIS_MAX_FRAME);
    // counter stops here, any value above MAX_LEN is already too long
    localparam axis_pkg::len_t SAT_LEN = axis_pkg::len_t'(`AXIS_MAX_FRAME + 1);

    // beats accepted before the current one in this frame
    axis_pkg::len_t beat_cnt;
    // beat count including the beat on the input now
    axis_pkg::len_t frame_len;
    logic           accept;
    logic           len_bad;

    // output register empty or draining this cycle
    assign in_tready = ~out_tvalid | out_tready;
    assign accept    = in_tvalid & in_tready;

    // saturating increment
    assign frame_len = (beat_cnt == SAT_LEN) ? SAT_LEN : beat_cnt + 1'b1;

    // only meaningful on the last beat
    assign len_bad = (frame_len < MIN_LEN) || (frame_len > MAX_LEN);

    // per frame beat counter
    always_ff @(posedge clk) begin
        if (!nrst) begin
            beat_cnt <= '0;
        end else if (accept) begin
            if (in_tlast) begin
                // next beat opens a new frame
                beat_cnt <= '0;
            end else begin
                beat_cnt <= frame_len;
            end
        end
    end

    // output valid
    always_ff @(posedge clk) begin
        if (!nrst) begin
            out_tvalid <= 1'b0;
        end else if (accept) begin
            out_tvalid <= 1'b1;
        end else if (out_tready) begin
            // drained with nothing new behind it
            out_tvalid <= 1'b0;
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        if (accept) begin
            out_tdata <= in_tdata;
            out_tlast <= in_tlast;
            // upstream error flag always survives
            // length verdict folded in on the last beat only
            out_tuser <= in_tuser | (in_tlast & len_bad);
        end
    end

endmodule

// File: src/axis_fifo.sv
`include "axis_cfg.svh"

module axis_fifo #(
    // log2 of the number of entries
    parameter int ADDR_WIDTH = `AXIS_FIFO_ADDR_WIDTH
) (
    input  logic            clk,
    input  logic            nrst,

    // write side stream
    input  axis_pkg::data_t input_axis_tdata,
    input  logic            input_axis_tvalid,
    output logic            input_axis_tready,
    input  logic            input_axis_tlast,
    input  logic            input_axis_tuser,

    // read side stream
    output axis_pkg::data_t output_axis_tdata,
    output logic            output_axis_tvalid,
    input  logic            output_axis_tready,
    output logic            output_axis_tlast,
    output logic            output_axis_tuser
);

    localparam int DATA_WIDTH = $bits(axis_pkg::data_t);
    // data plus last and user
    localparam int MEM_WIDTH  = DATA_WIDTH + 2;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;

    // pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0]  wr_ptr;
    logic [ADDR_WIDTH:0]  rd_ptr;

    // block ram storage
    logic [MEM_WIDTH-1:0] mem [DEPTH];
    logic [MEM_WIDTH-1:0] mem_wr_data;

    // prefetch register behind the ram read port
    logic [MEM_WIDTH-1:0] mem_rd_data;
    logic                 mem_rd_valid;

    // output register
    logic [MEM_WIDTH-1:0] out_data;

    logic full;
    logic empty;
    logic write;
    logic read;
    logic store_output;

    // wrap bits differ, index bits match
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    // pointers identical
    assign empty = (wr_ptr == rd_ptr);

    assign input_axis_tready = ~full;

    // pack flags above the data
    assign mem_wr_data = {input_axis_tlast, input_axis_tuser, input_axis_tdata};
    assign {output_axis_tlast, output_axis_tuser, output_axis_tdata} = out_data;

    // accept whenever there is room
    assign write = input_axis_tvalid & ~full;

    // output register taken or empty
    assign store_output = output_axis_tready | ~output_axis_tvalid;

    // refill prefetch when it moves on or holds nothing
    assign read = ~empty & (store_output | ~mem_rd_valid);

    // write pointer
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ram write port
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= mem_wr_data;
        end
    end

    // read pointer and prefetch valid
    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_ptr       <= '0;
            mem_rd_valid <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (store_output | ~mem_rd_valid) begin
                // loaded if anything stored, else goes empty
                mem_rd_valid <= ~empty;
            end
        end
    end

    // registered ram read port
    always_ff @(posedge clk) begin
        if (read) begin
            mem_rd_data <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // output valid follows prefetch when allowed to advance
    always_ff @(posedge clk) begin
        if (!nrst) begin
            output_axis_tvalid <= 1'b0;
        end else if (store_output) begin
            output_axis_tvalid <= mem_rd_valid;
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        if (store_output) begin
            out_data <= mem_rd_data;
        end
    end

endmodule

// File: src/axis_frame_stats.sv
module axis_frame_stats (
    input  logic            clk,
    input  logic            nrst,

    // stream from the fifo
    input  axis_pkg::data_t in_tdata,
    input  logic            in_tvalid,
    output logic            in_tready,
    input  logic            in_tlast,
    input  logic            in_tuser,

    // delivered stream
    output axis_pkg::data_t out_tdata,
    output logic            out_tvalid,
    input  logic            out_tready,
    output logic            out_tlast,
    output logic            out_tuser,

    // delivered frames and flagged frames
    output axis_pkg::cnt_t  frame_count,
    output axis_pkg::cnt_t  bad_count
);

    logic accept;
    // last beat leaving the output this cycle
    logic frame_done;

    // fill or drain rule
    assign in_tready  = ~out_tvalid | out_tready;
    assign accept     = in_tvalid & in_tready;
    assign frame_done = out_tvalid & out_tready & out_tlast;

    // output valid
    always_ff @(posedge clk) begin
        if (!nrst) begin
            out_tvalid <= 1'b0;
        end else if (accept) begin
            out_tvalid <= 1'b1;
        end else if (out_tready) begin
            out_tvalid <= 1'b0;
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        if (accept) begin
            out_tdata <= in_tdata;
            out_tlast <= in_tlast;
            out_tuser <= in_tuser;
        end
    end

    // counters update after the last beat is taken
    // both wrap silently
    always_ff @(posedge clk) begin
        if (!nrst) begin
            frame_count <= '0;
            bad_count   <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + 1'b1;
            // user on the last beat marks the whole frame bad
            if (out_tuser) begin
                bad_count <= bad_count + 1'b1;
            end
        end
    end

endmodule

// File: src/axis_frame_pipe.sv
`include "axis_cfg.svh"

module axis_frame_pipe (
    input  logic            clk,
    input  logic            nrst,

    // receive stream in
    input  axis_pkg::data_t s_tdata,
    input  logic            s_tvalid,
    output logic            s_tready,
    input  logic            s_tlast,
    input  logic            s_tuser,

    // checked stream out
    output axis_pkg::data_t m_tdata,
    output logic            m_tvalid,
    input  logic            m_tready,
    output logic            m_tlast,
    output logic            m_tuser,

    // delivery statistics
    output axis_pkg::cnt_t  frame_count,
    output axis_pkg::cnt_t  bad_count
);

    // length checker to fifo
    axis_pkg::data_t check_tdata;
    logic            check_tvalid;
    logic            check_tready;
    logic            check_tlast;
    logic            check_tuser;

    // fifo to stats stage
    axis_pkg::data_t fifo_tdata;
    logic            fifo_tvalid;
    logic            fifo_tready;
    logic            fifo_tlast;
    logic            fifo_tuser;

    // flags short and long frames
    axis_frame_check axis_frame_check_inst (
        .clk        (clk),
        .nrst       (nrst),
        .in_tdata   (s_tdata),
        .in_tvalid  (s_tvalid),
        .in_tready  (s_tready),
        .in_tlast   (s_tlast),
        .in_tuser   (s_tuser),
        .out_tdata  (check_tdata),
        .out_tvalid (check_tvalid),
        .out_tready (check_tready),
        .out_tlast  (check_tlast),
        .out_tuser  (check_tuser)
    );

    // elastic buffer absorbing output back-pressure
    axis_fifo #(
        .ADDR_WIDTH (`AXIS_FIFO_ADDR_WIDTH)
    ) axis_fifo_inst (
        .clk                (clk),
        .nrst               (nrst),
        .input_axis_tdata   (check_tdata),
        .input_axis_tvalid  (check_tvalid),
        .input_axis_tready  (check_tready),
        .input_axis_tlast   (check_tlast),
        .input_axis_tuser   (check_tuser),
        .output_axis_tdata  (fifo_tdata),
        .output_axis_tvalid (fifo_tvalid),
        .output_axis_tready (fifo_tready),
        .output_axis_tlast  (fifo_tlast),
        .output_axis_tuser  (fifo_tuser)
    );

    // output register and frame counters
    axis_frame_stats axis_frame_stats_inst (
        .clk         (clk),
        .nrst        (nrst),
        .in_tdata    (fifo_tdata),
        .in_tvalid   (fifo_tvalid),
        .in_tready   (fifo_tready),
        .in_tlast    (fifo_tlast),
        .in_tuser    (fifo_tuser),
        .out_tdata   (m_tdata),
        .out_tvalid  (m_tvalid),
        .out_tready  (m_tready),
        .out_tlast   (m_tlast),
        .out_tuser   (m_tuser),
        .frame_count (frame_count),
        .bad_count   (bad_count)
    );

endmodule

// File: sim/tb_axis_frame_pipe.sv
`include "axis_cfg.svh"

module tb_axis_frame_pipe;

    // frames per stream test
    localparam int NUM_FRAMES      = 40;
    localparam int CLK_PERIOD      = 100;
    // watchdog budget per beat
    localparam int CYCLES_PER_BEAT = 20;
    // quiet output cycles tolerated once all input is sent
    localparam int IDLE_LIMIT      = 64;
    localparam axis_pkg::len_t MIN_LEN = axis_pkg::len_t'(`AXIS_MIN_FRAME);
    localparam axis_pkg::len_t MAX_LEN = axis_pkg::len_t'(`AXIS_MAX_FRAME);

    logic            clk;
    logic            nrst;
    axis_pkg::data_t s_tdata;
    logic            s_tvalid;
    logic            s_tready;
    logic            s_tlast;
    logic            s_tuser;
    axis_pkg::data_t m_tdata;
    logic            m_tvalid;
    logic            m_tready;
    logic            m_tlast;
    logic            m_tuser;
    axis_pkg::cnt_t  frame_count;
    axis_pkg::cnt_t  bad_count;

    logic [15:0] lfsr_state;

    // generated beats for both stream tests
    axis_pkg::data_t stim_data[$];
    logic            stim_last[$];
    logic            stim_user[$];

    // reference model of expected output beats in order
    axis_pkg::data_t exp_data[$];
    logic            exp_last[$];
    logic            exp_user[$];
    axis_pkg::len_t  model_len;
    int              exp_frames;
    int              exp_bad;

    int total_beats = 0;
    int error_count;
    int user_errors;
    int failed_tests;
    int short_frames;
    int long_frames;
    int user_frames;
    logic stall_seen;

    axis_frame_pipe axis_frame_pipe_inst (
        .clk         (clk),
        .nrst        (nrst),
        .s_tdata     (s_tdata),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tlast     (s_tlast),
        .s_tuser     (s_tuser),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser),
        .frame_count (frame_count),
        .bad_count   (bad_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    // n fresh bits with one step per bit
    task automatic random_bits(input int n, output int unsigned value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // frames of 1 to 16 beats with input user on about one frame in eight
    task automatic build_frames(input int num_frames);
        int unsigned r;
        int len;
        int user_beat;
        logic has_user;
        for (int f = 0; f < num_frames; f++) begin
            random_bits(4, r);
            len = int'(r) + 1;
            random_bits(3, r);
            has_user = (r == 0);
            // user placed on one random beat of the frame
            random_bits(4, r);
            user_beat = int'(r) % len;
            if (len < `AXIS_MIN_FRAME) short_frames++;
            if (len > `AXIS_MAX_FRAME) long_frames++;
            if (has_user) user_frames++;
            for (int b = 0; b < len; b++) begin
                random_bits(8, r);
                stim_data.push_back(axis_pkg::data_t'(r));
                stim_last.push_back(b == len - 1);
                stim_user.push_back(has_user && (b == user_beat));
            end
        end
    endtask

    // beat accepted at the coming edge gets the length rule
    task automatic model_accept();
        logic bad;
        model_len = model_len + axis_pkg::len_t'(1);
        bad = s_tlast && ((model_len < MIN_LEN) || (model_len > MAX_LEN));
        exp_data.push_back(s_tdata);
        exp_last.push_back(s_tlast);
        exp_user.push_back(s_tuser | bad);
        if (s_tlast) begin
            exp_frames++;
            if (s_tuser || bad) exp_bad++;
            model_len = '0;
        end
    endtask

    task automatic take_output_beat();
        logic u;
        if (exp_data.size() == 0) begin
            $display("extra output beat at time %0t with nothing expected", $time);
            error_count++;
        end else begin
            check_value(32'(m_tdata), 32'(exp_data.pop_front()), "output data");
            check_value(32'(m_tlast), 32'(exp_last.pop_front()), "output last");
            u = exp_user.pop_front();
            if (m_tuser !== u) user_errors++;
            check_value(32'(m_tuser), 32'(u), "output user");
        end
    endtask

    // handshakes judged at the falling edge where readies and valids are stable
    task automatic run_stream(input int first_beat, input int end_beat,
                              input logic open_output);
        int unsigned r;
        int idx;
        int idle;
        logic holding;
        idx = first_beat;
        idle = 0;
        holding = 1'b0;
        while (idx < end_beat || (exp_data.size() != 0 && idle < IDLE_LIMIT)) begin
            @(negedge clk);
            // output side ready about 40 percent of the time under back-pressure
            if (open_output) begin
                m_tready = 1'b1;
            end else begin
                random_bits(5, r);
                m_tready = (r < 13);
            end
            if (m_tvalid && m_tready) begin
                take_output_beat();
                idle = 0;
            end else begin
                idle++;
            end
            // input side offers a new beat only once the old one is taken
            if (!holding) begin
                random_bits(2, r);
                if (idx < end_beat && r != 0) begin
                    s_tvalid = 1'b1;
                    s_tdata  = stim_data[idx];
                    s_tlast  = stim_last[idx];
                    s_tuser  = stim_user[idx];
                end else begin
                    s_tvalid = 1'b0;
                end
            end
            if (s_tvalid && !s_tready) stall_seen = 1'b1;
            if (s_tvalid && s_tready) begin
                model_accept();
                idx++;
                holding = 1'b0;
            end else begin
                holding = s_tvalid;
            end
        end
    endtask

    // open output for a while and expect nothing more
    task automatic drain_check();
        int extra;
        extra = 0;
        m_tready = 1'b1;
        repeat (30) begin
            @(negedge clk);
            if (m_tvalid) extra++;
        end
        check_value(32'(exp_data.size()), 32'd0, "beats left in model queue");
        if (extra != 0) begin
            $display("output kept delivering beats after the drain, %0d of them", extra);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, error_count - errors_before);
            failed_tests++;
        end
    endtask

    // timeout scaled to the generated stimulus
    initial begin
        int limit_cycles;
        wait (total_beats > 0);
        limit_cycles = total_beats * CYCLES_PER_BEAT + 100;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int mark;
        int split;
        nrst       = 1'b0;
        s_tdata    = '0;
        s_tvalid   = 1'b0;
        s_tlast    = 1'b0;
        s_tuser    = 1'b0;
        m_tready   = 1'b0;
        lfsr_state = 16'd11;
        model_len  = '0;
        exp_frames = 0;
        exp_bad    = 0;
        error_count  = 0;
        user_errors  = 0;
        failed_tests = 0;
        short_frames = 0;
        long_frames  = 0;
        user_frames  = 0;
        stall_seen   = 1'b0;
        build_frames(NUM_FRAMES);
        split = stim_data.size();
        build_frames(NUM_FRAMES);
        total_beats = stim_data.size();

        // reset held for four cycles
        mark = error_count;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value(32'(m_tvalid), 32'd0, "m_tvalid in reset");
            check_value(32'(frame_count), 32'd0, "frame_count in reset");
            check_value(32'(bad_count), 32'd0, "bad_count in reset");
        end
        nrst = 1'b1;
        @(negedge clk);
        check_value(32'(m_tvalid), 32'd0, "m_tvalid after reset");
        check_value(32'(frame_count), 32'd0, "frame_count after reset");
        check_value(32'(bad_count), 32'd0, "bad_count after reset");
        report_test("reset state", mark);

        mark = error_count;
        run_stream(0, split, 1'b1);
        drain_check();
        report_test("open output integrity", mark);

        mark = error_count;
        run_stream(split, total_beats, 1'b0);
        drain_check();
        check_value(32'(stall_seen), 32'd1, "input stalled by a full fifo");
        report_test("back-pressure", mark);

        // user flags were compared beat by beat in both streams
        mark = error_count;
        check_value(32'(user_errors), 32'd0, "user flag mismatches");
        check_value(32'(short_frames > 0), 32'd1, "short frames generated");
        check_value(32'(long_frames > 0), 32'd1, "long frames generated");
        check_value(32'(user_frames > 0), 32'd1, "input user frames generated");
        report_test("length check", mark);

        mark = error_count;
        check_value(32'(frame_count), 32'(axis_pkg::cnt_t'(exp_frames)), "frame_count");
        check_value(32'(bad_count), 32'(axis_pkg::cnt_t'(exp_bad)), "bad_count");
        report_test("statistics", mark);

        $display("tests run 5, tests failed %0d, errors %0d, beats %0d",
                 failed_tests, error_count, total_beats);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/axis_pkg.sv
src/axis_frame_check.sv
src/axis_fifo.sv
src/axis_frame_stats.sv
src/axis_frame_pipe.sv
sim/tb_axis_frame_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build and run the frame pipe testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f all.f \
    --top-module tb_axis_frame_pipe \
    -o tb_axis_frame_pipe

./obj_dir/tb_axis_frame_pipe | tee sim.log

# the log decides the verdict
if grep -q "Simulation failed" sim.log; then
    echo "run_sim: failure reported"
    exit 1
fi

grep -q "Simulation passed" sim.log
echo "run_sim: done"
